// File: core_pkg.sv
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 4;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // fetch -> decode
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_id_t;

    // decode -> execute
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rd;
        alu_op_e               alu_op;
        // operand a from pc, operand b from imm
        logic                  src1_pc;
        logic                  src2_imm;
        logic                  wen;
        logic                  bne;
        logic                  branch;
        logic                  jal;
        logic                  jalr;
        logic                  ebreak;
    } id_ex_t;

    // execute -> writeback
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       pc_next;
        logic [XLEN-1:0]       result;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic                  ebreak;
    } ex_wb_t;

endpackage

// File: isa_pkg.sv
package isa_pkg;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct3 for branches
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // sub shares funct3 with add
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // full word, no operand fields
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

endpackage

// File: rv_stage_reg.sv
`timescale 1ns/100ps

module rv_stage_reg #(
    parameter type T_PAYLOAD = logic
) (
    input  logic     clock,
    input  logic     i_rst,
    input  logic     i_flush,
    input  logic     i_valid,
    output logic     o_ready,
    input  T_PAYLOAD i_payload,
    output logic     o_valid,
    input  logic     i_ready,
    output T_PAYLOAD o_payload
);

    logic     valid_q;
    T_PAYLOAD payload_q;

    // empty, or the held item leaves this cycle
    assign o_ready = !valid_q || i_ready;

    always_ff @(posedge clock) begin
        if (i_rst || i_flush) begin
            valid_q <= 1'b0;
        end else if (o_ready) begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (i_valid && o_ready) begin
            payload_q <= i_payload;
        end
    end

    assign o_valid   = valid_q;
    assign o_payload = payload_q;

endmodule

// File: rv_fetch.sv
`timescale 1ns/100ps

module rv_fetch
    import core_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clock,
    input  logic            i_rst,
    input  logic            i_pc_update,
    input  logic [XLEN-1:0] i_pc_next,
    input  logic            i_halt,
    input  logic            i_imem_valid,
    input  logic [XLEN-1:0] i_imem_data,
    output logic            o_imem_req,
    output logic [XLEN-1:0] o_imem_addr,
    output logic            o_valid,
    output if_id_t          o_payload
);

    logic [XLEN-1:0] pc_q;
    // first request after reset still owed
    logic            boot_q;
    logic            req_q;
    logic            wait_q;

    always_ff @(posedge clock) begin
        if (i_rst) begin
            pc_q   <= RESET_PC;
            boot_q <= 1'b1;
            req_q  <= 1'b0;
            wait_q <= 1'b0;
        end else begin
            boot_q <= 1'b0;
            req_q  <= (boot_q || i_pc_update) && !i_halt;
            if (i_pc_update) begin
                pc_q <= i_pc_next;
            end
            // memory never answers in the request cycle
            if (req_q) begin
                wait_q <= 1'b1;
            end else if (i_imem_valid) begin
                wait_q <= 1'b0;
            end
        end
    end

    assign o_imem_req  = req_q;
    assign o_imem_addr = pc_q;

    assign o_valid   = wait_q && i_imem_valid;
    assign o_payload = '{pc: pc_q, instr: i_imem_data};

endmodule

// File: rv_decode.sv
`timescale 1ns/100ps

module rv_decode
    import core_pkg::*;
    import isa_pkg::*;
(
    input  if_id_t                i_payload,
    input  logic [XLEN-1:0]       i_rs1_data,
    input  logic [XLEN-1:0]       i_rs2_data,
    output logic [REG_ADDR_W-1:0] o_rs1_addr,
    output logic [REG_ADDR_W-1:0] o_rs2_addr,
    output id_ex_t                o_payload
);

    logic [XLEN-1:0]       instr;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_u;
    logic [XLEN-1:0]       imm_j;
    logic [XLEN-1:0]       imm_b;

    assign instr  = i_payload.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // only the low four bits of each register field
    assign rd         = instr[7 +: REG_ADDR_W];
    assign o_rs1_addr = instr[15 +: REG_ADDR_W];
    assign o_rs2_addr = instr[20 +: REG_ADDR_W];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        o_payload          = '0;
        o_payload.pc       = i_payload.pc;
        o_payload.rs1_data = i_rs1_data;
        o_payload.rs2_data = i_rs2_data;
        o_payload.rd       = rd;
        o_payload.imm      = imm_i;
        o_payload.alu_op   = ALU_ADD;

        case (opcode)
            OPC_OP: begin
                o_payload.wen = 1'b1;
                case (funct3)
                    F3_ADD:  o_payload.alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_AND:  o_payload.alu_op = ALU_AND;
                    F3_OR:   o_payload.alu_op = ALU_OR;
                    F3_XOR:  o_payload.alu_op = ALU_XOR;
                    F3_SLT:  o_payload.alu_op = ALU_SLT;
                    default: o_payload.wen = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // addi only
                o_payload.wen      = (funct3 == F3_ADD);
                o_payload.src2_imm = 1'b1;
            end
            OPC_LUI: begin
                o_payload.wen      = 1'b1;
                o_payload.imm      = imm_u;
                o_payload.src2_imm = 1'b1;
                o_payload.alu_op   = ALU_PASS_B;
            end
            OPC_JAL: begin
                // alu forms the target pc + imm
                o_payload.wen      = 1'b1;
                o_payload.jal      = 1'b1;
                o_payload.imm      = imm_j;
                o_payload.src1_pc  = 1'b1;
                o_payload.src2_imm = 1'b1;
            end
            OPC_JALR: begin
                o_payload.wen      = 1'b1;
                o_payload.jalr     = 1'b1;
                o_payload.src2_imm = 1'b1;
            end
            OPC_BRANCH: begin
                o_payload.branch   = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                o_payload.bne      = (funct3 == F3_BNE);
                o_payload.imm      = imm_b;
                o_payload.src1_pc  = 1'b1;
                o_payload.src2_imm = 1'b1;
            end
            OPC_SYSTEM: begin
                o_payload.ebreak = (instr == EBREAK_WORD);
            end
            default: begin
                // unknown opcode falls through as a no-write
                o_payload.wen = 1'b0;
            end
        endcase

        // x0 is never a real destination
        if (rd == '0) begin
            o_payload.wen = 1'b0;
        end
    end

endmodule

// File: rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile
    import core_pkg::*;
(
    input  logic                  clock,
    input  logic                  i_rst,
    input  logic                  i_wen,
    input  logic [REG_ADDR_W-1:0] i_waddr,
    input  logic [XLEN-1:0]       i_wdata,
    input  logic [REG_ADDR_W-1:0] i_raddr1,
    input  logic [REG_ADDR_W-1:0] i_raddr2,
    output logic [XLEN-1:0]       o_rdata1,
    output logic [XLEN-1:0]       o_rdata2
);

    localparam int NUM_REGS = 1 << REG_ADDR_W;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clock) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wen && (i_waddr != '0)) begin
            // x0 stays at its reset value
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata1 = regs[i_raddr1];
    assign o_rdata2 = regs[i_raddr2];

endmodule

// File: rv_execute.sv
`timescale 1ns/100ps

module rv_execute
    import core_pkg::*;
(
    input  id_ex_t i_payload,
    output ex_wb_t o_payload
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] pc_plus4;
    logic            slt_bit;
    logic            rs_equal;
    logic            taken;

    assign op_a = i_payload.src1_pc ? i_payload.pc : i_payload.rs1_data;
    assign op_b = i_payload.src2_imm ? i_payload.imm : i_payload.rs2_data;

    assign slt_bit = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (i_payload.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, slt_bit};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    // branch compare always on the register values
    assign rs_equal = (i_payload.rs1_data == i_payload.rs2_data);
    assign taken    = i_payload.branch && (rs_equal ^ i_payload.bne);
    assign pc_plus4 = i_payload.pc + XLEN'(4);

    always_comb begin
        o_payload        = '0;
        o_payload.pc     = i_payload.pc;
        o_payload.rd     = i_payload.rd;
        o_payload.wen    = i_payload.wen;
        o_payload.ebreak = i_payload.ebreak;

        if (i_payload.jalr) begin
            o_payload.pc_next = {alu_res[XLEN-1:1], 1'b0};
        end else if (i_payload.jal || taken) begin
            o_payload.pc_next = alu_res;
        end else begin
            o_payload.pc_next = pc_plus4;
        end

        // link value for jumps
        if (i_payload.jal || i_payload.jalr) begin
            o_payload.result = pc_plus4;
        end else begin
            o_payload.result = alu_res;
        end
    end

endmodule

// File: rv_writeback.sv
`timescale 1ns/100ps

module rv_writeback
    import core_pkg::*;
(
    input  logic                  clock,
    input  logic                  i_rst,
    input  logic                  i_valid,
    input  ex_wb_t                i_payload,
    output logic                  o_rf_wen,
    output logic [REG_ADDR_W-1:0] o_rf_waddr,
    output logic [XLEN-1:0]       o_rf_wdata,
    output logic                  o_pc_update,
    output logic [XLEN-1:0]       o_pc_next,
    output logic                  o_retire_valid,
    output logic [XLEN-1:0]       o_retire_pc,
    output logic                  o_retire_wen,
    output logic [REG_ADDR_W-1:0] o_retire_rd,
    output logic [XLEN-1:0]       o_retire_wdata,
    output logic                  o_halt
);

    logic halt_q;

    assign o_rf_wen   = i_valid && i_payload.wen;
    assign o_rf_waddr = i_payload.rd;
    assign o_rf_wdata = i_payload.result;

    // ebreak retires without a redirect, so fetch stays idle
    assign o_pc_update = i_valid && !i_payload.ebreak;
    assign o_pc_next   = i_payload.pc_next;

    assign o_retire_valid = i_valid;
    assign o_retire_pc    = i_payload.pc;
    assign o_retire_wen   = o_rf_wen;
    assign o_retire_rd    = i_payload.rd;
    assign o_retire_wdata = i_payload.result;

    always_ff @(posedge clock) begin
        if (i_rst) begin
            halt_q <= 1'b0;
        end else if (i_valid && i_payload.ebreak) begin
            halt_q <= 1'b1;
        end
    end

    assign o_halt = halt_q;

endmodule

// File: rv_core.sv
`timescale 1ns/100ps

module rv_core
    import core_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic                  clock,
    input  logic                  i_rst,
    input  logic                  i_imem_valid,
    input  logic [XLEN-1:0]       i_imem_data,
    output logic                  o_imem_req,
    output logic [XLEN-1:0]       o_imem_addr,
    output logic                  o_retire_valid,
    output logic [XLEN-1:0]       o_retire_pc,
    output logic                  o_retire_wen,
    output logic [REG_ADDR_W-1:0] o_retire_rd,
    output logic [XLEN-1:0]       o_retire_wdata,
    output logic                  o_halt
);

    logic                  fetch_valid;
    if_id_t                fetch_payload;
    logic                  if_id_valid;
    if_id_t                if_id_payload;
    logic                  id_ex_ready;
    id_ex_t                dec_payload;
    logic                  id_ex_valid;
    id_ex_t                id_ex_payload;
    logic                  ex_wb_ready;
    ex_wb_t                exe_payload;
    logic                  ex_wb_valid;
    ex_wb_t                ex_wb_payload;

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  rf_wen;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;

    logic                  pc_update;
    logic [XLEN-1:0]       pc_next;

    rv_fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clock,
        .i_rst,
        .i_pc_update  (pc_update),
        .i_pc_next    (pc_next),
        .i_halt       (o_halt),
        .i_imem_valid,
        .i_imem_data,
        .o_imem_req,
        .o_imem_addr,
        .o_valid      (fetch_valid),
        .o_payload    (fetch_payload)
    );

    // fetch has no stall path, one word in flight at most
    rv_stage_reg #(
        .T_PAYLOAD (if_id_t)
    ) u_if_id (
        .clock,
        .i_rst,
        .i_flush   (pc_update),
        .i_valid   (fetch_valid),
        .o_ready   (),
        .i_payload (fetch_payload),
        .o_valid   (if_id_valid),
        .i_ready   (id_ex_ready),
        .o_payload (if_id_payload)
    );

    rv_decode u_decode (
        .i_payload  (if_id_payload),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_rs1_addr (rs1_addr),
        .o_rs2_addr (rs2_addr),
        .o_payload  (dec_payload)
    );

    rv_regfile u_regfile (
        .clock,
        .i_rst,
        .i_wen    (rf_wen),
        .i_waddr  (rf_waddr),
        .i_wdata  (rf_wdata),
        .i_raddr1 (rs1_addr),
        .i_raddr2 (rs2_addr),
        .o_rdata1 (rs1_data),
        .o_rdata2 (rs2_data)
    );

    rv_stage_reg #(
        .T_PAYLOAD (id_ex_t)
    ) u_id_ex (
        .clock,
        .i_rst,
        .i_flush   (pc_update),
        .i_valid   (if_id_valid),
        .o_ready   (id_ex_ready),
        .i_payload (dec_payload),
        .o_valid   (id_ex_valid),
        .i_ready   (ex_wb_ready),
        .o_payload (id_ex_payload)
    );

    rv_execute u_execute (
        .i_payload (id_ex_payload),
        .o_payload (exe_payload)
    );

    // writeback never stalls
    rv_stage_reg #(
        .T_PAYLOAD (ex_wb_t)
    ) u_ex_wb (
        .clock,
        .i_rst,
        .i_flush   (pc_update),
        .i_valid   (id_ex_valid),
        .o_ready   (ex_wb_ready),
        .i_payload (exe_payload),
        .o_valid   (ex_wb_valid),
        .i_ready   (1'b1),
        .o_payload (ex_wb_payload)
    );

    rv_writeback u_writeback (
        .clock,
        .i_rst,
        .i_valid        (ex_wb_valid),
        .i_payload      (ex_wb_payload),
        .o_rf_wen       (rf_wen),
        .o_rf_waddr     (rf_waddr),
        .o_rf_wdata     (rf_wdata),
        .o_pc_update    (pc_update),
        .o_pc_next      (pc_next),
        .o_retire_valid,
        .o_retire_pc,
        .o_retire_wen,
        .o_retire_rd,
        .o_retire_wdata,
        .o_halt
    );

endmodule

// File: rv_core_props.sv
`timescale 1ns/100ps

module rv_core_props
    import core_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input logic                  clock,
    input logic                  i_rst,
    input logic                  i_imem_valid,
    input logic                  i_imem_req,
    input logic [XLEN-1:0]       i_imem_addr,
    input logic                  i_retire_valid,
    input logic                  i_retire_wen,
    input logic [REG_ADDR_W-1:0] i_retire_rd,
    input logic                  i_halt
);

    int   fail_count = 0;
    logic rst_q;
    // request sent, word not back yet
    logic pending;

    always_ff @(posedge clock) begin
        rst_q <= i_rst;
        if (i_rst) begin
            pending <= 1'b0;
        end else if (i_imem_req) begin
            pending <= 1'b1;
        end else if (i_imem_valid) begin
            pending <= 1'b0;
        end
    end

    task automatic note_failure(string msg);
        fail_count++;
        $error("%s", msg);
    endtask

    a_req_pulse: assert property (@(posedge clock) disable iff (i_rst)
        i_imem_req |=> !i_imem_req) else note_failure("imem request longer than one cycle");
    a_req_idle: assert property (@(posedge clock) disable iff (i_rst)
        i_imem_req |-> !pending) else note_failure("imem request while a word is owed");
    a_retire_lat: assert property (@(posedge clock) disable iff (i_rst)
        i_imem_valid |-> ##3 i_retire_valid) else note_failure("no retire 3 cycles after fetch");
    a_retire_src: assert property (@(posedge clock) disable iff (i_rst)
        i_retire_valid |-> $past(i_imem_valid, 3)) else note_failure("retire without a fetch");
    // exactly one of next fetch and halt
    a_next_req: assert property (@(posedge clock) disable iff (i_rst)
        i_retire_valid |=> (i_imem_req != i_halt)) else note_failure("bad cycle after retire");
    a_halt_rise: assert property (@(posedge clock) disable iff (i_rst)
        $rose(i_halt) |-> $past(i_retire_valid)) else note_failure("halt without a retire");
    a_halt_hold: assert property (@(posedge clock) disable iff (i_rst)
        i_halt |=> i_halt) else note_failure("halt dropped before reset");
    a_halt_quiet: assert property (@(posedge clock) disable iff (i_rst)
        i_halt |-> !i_imem_req && !i_retire_valid) else note_failure("activity after halt");
    a_x0_wen: assert property (@(posedge clock) disable iff (i_rst)
        i_retire_valid && i_retire_wen |-> i_retire_rd != '0) else note_failure("x0 written");
    a_in_reset: assert property (@(posedge clock)
        i_rst && rst_q |-> !i_retire_valid && !i_halt && !i_imem_req)
        else note_failure("outputs active during reset");
    a_boot: assert property (@(posedge clock)
        $fell(i_rst) |-> (!i_retire_valid && !i_halt) ##1 (i_imem_req && i_imem_addr == RESET_PC))
        else note_failure("first fetch missing or not at the reset pc");

endmodule

bind rv_core rv_core_props #(
    .RESET_PC (RESET_PC)
) u_props (
    .clock,
    .i_rst,
    .i_imem_valid,
    .i_imem_req     (o_imem_req),
    .i_imem_addr    (o_imem_addr),
    .i_retire_valid (o_retire_valid),
    .i_retire_wen   (o_retire_wen),
    .i_retire_rd    (o_retire_rd),
    .i_halt         (o_halt)
);

// File: rv_core_tb.sv
`timescale 1ns/100ps

module rv_core_tb
    import core_pkg::*;
    import isa_pkg::*;
();

    localparam int              PROG_LEN    = 24;
    localparam int              EXP_RETIRES = 19;
    localparam int              CLK_PERIOD  = 8;
    localparam logic [XLEN-1:0] RESET_PC    = 32'h0000_0100;

    logic                  clock = 1'b0;
    logic                  i_rst;
    logic                  i_imem_valid;
    logic [XLEN-1:0]       i_imem_data;
    logic                  o_imem_req;
    logic [XLEN-1:0]       o_imem_addr;
    logic                  o_retire_valid;
    logic [XLEN-1:0]       o_retire_pc;
    logic                  o_retire_wen;
    logic [REG_ADDR_W-1:0] o_retire_rd;
    logic [XLEN-1:0]       o_retire_wdata;
    logic                  o_halt;

    logic [XLEN-1:0] prog [PROG_LEN];
    // reference model state
    logic [XLEN-1:0] m_regs [16] = '{default: '0};
    logic [XLEN-1:0] m_pc = RESET_PC;
    logic            m_halted = 1'b0;
    int              retires = 0;
    int              checks = 0;
    int              errors = 0;
    integer          seed = 21;

    always #(CLK_PERIOD / 2) clock = ~clock;

    rv_core #(
        .RESET_PC (RESET_PC)
    ) u_rv_core (.*);

    function automatic logic [31:0] r_type(logic [2:0] f3, logic [6:0] f7, int rd, int rs1,
                                           int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(logic [6:0] opc, logic [2:0] f3, int rd, int rs1,
                                           int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] lui_word(int rd, logic [19:0] imm20);
        return {imm20, 5'(rd), OPC_LUI};
    endfunction

    function automatic logic [31:0] jal_word(int rd, int offset);
        logic [20:0] o;
        o = 21'(offset);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), OPC_JAL};
    endfunction

    function automatic logic [31:0] branch_word(logic [2:0] f3, int rs1, int rs2, int offset);
        logic [12:0] o;
        o = 13'(offset);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], OPC_BRANCH};
    endfunction

    function automatic logic [XLEN-1:0] word_at(logic [XLEN-1:0] addr);
        logic [XLEN-1:0] offset;
        offset = addr - RESET_PC;
        if (offset[XLEN-1:2] < PROG_LEN) begin
            return prog[offset[XLEN-1:2]];
        end
        return '0;
    endfunction

    task automatic log_failure(string msg);
        errors++;
        $display("CHECK FAILED at time %0t: %s", $time, msg);
    endtask

    initial begin
        prog[0]  = i_type(OPC_OP_IMM, F3_ADD, 1, 0, 5);
        prog[1]  = i_type(OPC_OP_IMM, F3_ADD, 2, 0, -3);
        prog[2]  = r_type(F3_ADD, 7'b0, 3, 1, 2);
        prog[3]  = r_type(F3_ADD, F7_SUB, 4, 1, 2);
        prog[4]  = r_type(F3_AND, 7'b0, 5, 1, 2);
        prog[5]  = r_type(F3_OR, 7'b0, 6, 1, 2);
        prog[6]  = r_type(F3_XOR, 7'b0, 7, 1, 2);
        prog[7]  = r_type(F3_SLT, 7'b0, 8, 2, 1);
        prog[8]  = r_type(F3_SLT, 7'b0, 9, 1, 2);
        prog[9]  = lui_word(10, 20'h12345);
        // write to x0, then read it back through x11
        prog[10] = i_type(OPC_OP_IMM, F3_ADD, 0, 1, 7);
        prog[11] = r_type(F3_ADD, 7'b0, 11, 0, 1);
        prog[12] = branch_word(F3_BEQ, 1, 11, 8);
        prog[13] = i_type(OPC_OP_IMM, F3_ADD, 12, 0, 99);
        prog[14] = branch_word(F3_BNE, 1, 11, 8);
        prog[15] = jal_word(13, 8);
        prog[16] = i_type(OPC_OP_IMM, F3_ADD, 12, 0, 77);
        // absolute jalr base
        prog[17] = i_type(OPC_OP_IMM, F3_ADD, 14, 0, int'(RESET_PC) + 84);
        // bit 0 of the odd target is dropped
        prog[18] = i_type(OPC_JALR, 3'b000, 15, 14, 1);
        prog[19] = i_type(OPC_OP_IMM, F3_ADD, 12, 0, 55);
        prog[20] = i_type(OPC_OP_IMM, F3_ADD, 12, 0, 66);
        prog[21] = branch_word(F3_BNE, 1, 2, 8);
        prog[22] = i_type(OPC_OP_IMM, F3_ADD, 12, 0, 44);
        prog[23] = EBREAK_WORD;
    end

    // instruction memory answers after 1 to 3 cycles
    initial begin
        int              latency;
        logic [XLEN-1:0] addr;
        i_imem_valid = 1'b0;
        i_imem_data  = '0;
        forever begin
            @(negedge clock);
            if (o_imem_req === 1'b1) begin
                addr    = o_imem_addr;
                latency = 1 + ($unsigned($random(seed)) % 3);
                repeat (latency) @(posedge clock);
                #1;
                i_imem_valid = 1'b1;
                i_imem_data  = word_at(addr);
                @(posedge clock);
                #1;
                i_imem_valid = 1'b0;
            end
        end
    end

    // reference model steps once per retire
    always @(negedge clock) begin
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] wd;
        logic [XLEN-1:0] next_pc;
        logic            wen;
        logic [3:0]      rd;
        if (!i_rst && o_retire_valid === 1'b1) begin
            instr   = word_at(m_pc);
            a       = m_regs[instr[18:15]];
            b       = m_regs[instr[23:20]];
            imm     = {{20{instr[31]}}, instr[31:20]};
            rd      = instr[10:7];
            wd      = '0;
            wen     = 1'b0;
            next_pc = m_pc + 4;
            case (instr[6:0])
                OPC_OP: begin
                    wen = 1'b1;
                    case (instr[14:12])
                        F3_ADD:  wd = (instr[31:25] == F7_SUB) ? a - b : a + b;
                        F3_AND:  wd = a & b;
                        F3_OR:   wd = a | b;
                        F3_XOR:  wd = a ^ b;
                        F3_SLT:  wd = XLEN'($signed(a) < $signed(b));
                        default: wen = 1'b0;
                    endcase
                end
                OPC_OP_IMM: begin
                    wen = (instr[14:12] == F3_ADD);
                    wd  = a + imm;
                end
                OPC_LUI: begin
                    wen = 1'b1;
                    wd  = {instr[31:12], 12'b0};
                end
                OPC_JAL: begin
                    wen     = 1'b1;
                    wd      = m_pc + 4;
                    next_pc = m_pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21],
                                      1'b0};
                end
                OPC_JALR: begin
                    wen     = 1'b1;
                    wd      = m_pc + 4;
                    next_pc = (a + imm) & ~XLEN'(1);
                end
                OPC_BRANCH: begin
                    if ((a == b) != (instr[14:12] == F3_BNE)) begin
                        next_pc = m_pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8],
                                          1'b0};
                    end
                end
                default: begin
                    wen = 1'b0;
                end
            endcase
            wen = wen && (rd != 0);
            checks += 5;
            assert (!m_halted)
                else log_failure("retire seen after the halting instruction");
            assert (o_retire_pc === m_pc)
                else log_failure($sformatf("retire pc %h, expected %h", o_retire_pc, m_pc));
            assert (o_retire_rd === rd)
                else log_failure($sformatf("retire rd %0d, expected %0d", o_retire_rd, rd));
            assert (o_retire_wen === wen)
                else log_failure($sformatf("retire wen %b, expected %b", o_retire_wen, wen));
            assert (!wen || o_retire_wdata === wd)
                else log_failure($sformatf("x%0d written %h, expected %h", rd, o_retire_wdata,
                                           wd));
            if (wen) begin
                m_regs[rd] = wd;
            end
            if (instr == EBREAK_WORD) begin
                m_halted = 1'b1;
            end
            m_pc = next_pc;
            retires++;
        end
    end

    initial begin
        i_rst = 1'b1;
        repeat (3) @(posedge clock);
        #1;
        i_rst = 1'b0;
        wait (o_halt === 1'b1);
        // quiet bus after halt
        repeat (10) @(posedge clock);
        checks++;
        assert (m_halted && retires == EXP_RETIRES)
            else log_failure($sformatf("halted after %0d retires, expected %0d", retires,
                                       EXP_RETIRES));
        $display("retires %0d, checks %0d, model errors %0d, property errors %0d",
                 retires, checks, errors, u_rv_core.u_props.fail_count);
        if (errors == 0 && u_rv_core.u_props.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(PROG_LEN * 60 * CLK_PERIOD);
        $display("timeout: the core did not halt within %0d cycles", PROG_LEN * 60);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: verilog.f
core_pkg.sv
isa_pkg.sv
rv_stage_reg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_writeback.sv
rv_core.sv
rv_core_props.sv
rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - files:
      - core_pkg.sv
      - isa_pkg.sv
      - rv_stage_reg.sv
      - rv_fetch.sv
      - rv_decode.sv
      - rv_regfile.sv
      - rv_execute.sv
      - rv_writeback.sv
      - rv_core.sv
  - target: test
    files:
      - rv_core_props.sv
      - rv_core_tb.sv
